//--- Bender.yml
package:
  name: synth_controller

export_include_dirs:
  - include

sources:
  - design/synth_pkg.sv
  - design/midi_uart_rx.sv
  - design/cpu_port.sv
  - design/midi_parser.sv
  - design/note_stack.sv
  - design/ctrl_regs.sv
  - design/synth_controller.sv
  - target: test
    files:
      - test/synth_controller_sva.sv
      - test/tb_synth_controller.sv

//--- all.f
+incdir+include
design/synth_pkg.sv
design/midi_uart_rx.sv
design/cpu_port.sv
design/midi_parser.sv
design/note_stack.sv
design/ctrl_regs.sv
design/synth_controller.sv
test/synth_controller_sva.sv
test/tb_synth_controller.sv

//--- design/cpu_port.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_port (
    input  wire         reg_clk,
    input  wire         reset_reg_N,
    input  wire  [2:0]  socmidi_addr,
    input  wire  [7:0]  socmidi_data_in,
    input  wire         socmidi_write,
    output logic        cpu_strobe,         // byte injected into MIDI stream
    output logic [7:0]  cpu_byte,
    output logic        omni                // accept all channels
);

    logic wr_byte;                          // write to address 0
    logic wr_mode;                          // write to address 1

    assign wr_byte = socmidi_write && (socmidi_addr == 3'd0);
    assign wr_mode = socmidi_write && (socmidi_addr == 3'd1);

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            cpu_strobe <= 1'b0;
            omni       <= 1'b0;
        end else begin
            cpu_strobe <= wr_byte;          // strobe one cycle after write
            if (wr_mode)
                omni <= socmidi_data_in[0];
        end
    end

    always_ff @(posedge reg_clk) begin
        if (wr_byte)
            cpu_byte <= socmidi_data_in;
    end

endmodule

`default_nettype wire

//--- design/ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs import synth_pkg::*; (
    input  wire         reg_clk,
    input  wire         reset_reg_N,
    input  wire         ev_strobe,
    input  msg_kind_e   ev_kind,
    input  wire  [6:0]  ev_d1,
    input  wire  [6:0]  ev_d2,
    output logic        ctrl_cmd,           // control change pulse
    output logic        prg_ch_cmd,         // program change pulse
    output logic        pitch_cmd,          // pitch bend pulse
    output logic [7:0]  octrl,              // ctrl number or bend lsb
    output logic [7:0]  octrl_data,         // ctrl value or bend msb
    output logic [7:0]  prg_ch_data
);

    logic is_ctrl;
    logic is_prg;
    logic is_pitch;

    assign is_ctrl  = ev_strobe && (ev_kind == kind_ctrl);
    assign is_prg   = ev_strobe && (ev_kind == kind_prg);
    assign is_pitch = ev_strobe && (ev_kind == kind_pitch);

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            ctrl_cmd   <= 1'b0;
            prg_ch_cmd <= 1'b0;
            pitch_cmd  <= 1'b0;
        end else begin
            ctrl_cmd   <= is_ctrl;
            prg_ch_cmd <= is_prg;
            pitch_cmd  <= is_pitch;
        end
    end

    always_ff @(posedge reg_clk) begin
        if (is_ctrl || is_pitch) begin      // shared data pair
            octrl      <= {1'b0, ev_d1};
            octrl_data <= {1'b0, ev_d2};
        end
        if (is_prg)
            prg_ch_data <= {1'b0, ev_d1};
    end

endmodule

`default_nettype wire

//--- design/midi_parser.sv
`timescale 1ns/1ps
`default_nettype none

module midi_parser import synth_pkg::*; (
    input  wire         reg_clk,
    input  wire         reset_reg_N,
    input  wire         uart_usb_sel,       // 1 serial in, 0 cpu port
    input  wire         rx_strobe,
    input  wire  [7:0]  rx_byte,
    input  wire         cpu_strobe,
    input  wire  [7:0]  cpu_byte,
    input  wire  [3:0]  midi_ch,
    input  wire         omni,
    output logic        ev_strobe,          // one cycle per accepted message
    output msg_kind_e   ev_kind,
    output logic [6:0]  ev_d1,
    output logic [6:0]  ev_d2
);

    logic       byte_v;                     // selected byte strobe
    logic [7:0] byte_d;
    logic [7:0] run_status;                 // bit 7 low means none
    logic       got_first;                  // first of two data bytes seen
    logic [6:0] first_d;
    logic       two_bytes;                  // message has two data bytes
    logic       ch_match;
    logic       done;                       // this byte completes a message
    msg_kind_e  cur_kind;

    assign byte_v = uart_usb_sel ? rx_strobe : cpu_strobe;
    assign byte_d = uart_usb_sel ? rx_byte : cpu_byte;

    // program change and channel pressure carry one data byte
    assign two_bytes = (run_status[6:4] != 3'h4) && (run_status[6:4] != 3'h5);
    assign ch_match  = omni || (run_status[3:0] == midi_ch);
    assign done = byte_v && !byte_d[7] && run_status[7] && (got_first || !two_bytes);

    always_comb begin
        case (run_status[7:4])
            4'h8: cur_kind = kind_note_off;
            4'h9: cur_kind = (byte_d[6:0] == 7'd0) ? kind_note_off : kind_note_on;
            4'hb: cur_kind = kind_ctrl;
            4'hc: cur_kind = kind_prg;
            4'he: cur_kind = kind_pitch;
            4'ha, 4'hd: cur_kind = kind_other; // aftertouch
            default: cur_kind = kind_none;
        endcase
    end

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            run_status <= 8'h00;
            got_first  <= 1'b0;
            ev_strobe  <= 1'b0;
            ev_kind    <= kind_none;
        end else begin
            ev_strobe <= 1'b0;
            if (byte_v) begin
                if (byte_d[7]) begin
                    if (byte_d[7:4] != 4'hf) begin // channel status
                        run_status <= byte_d;
                        got_first  <= 1'b0;
                    end else if (!byte_d[3]) begin // sysex and common
                        run_status <= 8'h00;
                        got_first  <= 1'b0;
                    end                     // realtime leaves state alone
                end else if (run_status[7]) begin
                    got_first <= !done;     // rearm for running status
                end
            end
            if (done) begin
                ev_strobe <= ch_match;
                ev_kind   <= cur_kind;
            end
        end
    end

    // data payload
    always_ff @(posedge reg_clk) begin
        if (byte_v && !byte_d[7] && !got_first)
            first_d <= byte_d[6:0];
        if (done) begin
            ev_d1 <= two_bytes ? first_d : byte_d[6:0];
            ev_d2 <= two_bytes ? byte_d[6:0] : 7'd0;
        end
    end

endmodule

`default_nettype wire

//--- design/midi_uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "synth_macros.svh"

module midi_uart_rx import synth_pkg::*; (
    input  wire         reg_clk,
    input  wire         reset_reg_N,
    input  wire         midi_rxd,           // serial MIDI in, idle high
    output logic        rx_strobe,          // one cycle, byte valid
    output logic [7:0]  rx_byte
);

    localparam int unsigned CPB = `MIDI_CLKS_PER_BIT;
    localparam int unsigned CNT_W = $clog2(CPB);
    localparam logic [CNT_W-1:0] HALF = CNT_W'(CPB / 2 - 1); // mid start bit
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CPB - 1);     // one full bit

    logic [1:0]       rxd_sync;             // two flop synchronizer
    logic             rxd;
    rx_state_e        state;
    logic [CNT_W-1:0] cnt;                  // clocks inside current bit
    logic [2:0]       bit_cnt;              // data bit index
    logic [7:0]       shreg;

    assign rxd = rxd_sync[1];
    assign rx_byte = shreg;                 // stable until next data bit

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            rxd_sync  <= 2'b11;             // line idles high
            state     <= rx_idle;
            cnt       <= '0;
            bit_cnt   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rxd_sync  <= {rxd_sync[0], midi_rxd};
            rx_strobe <= 1'b0;
            cnt       <= cnt + 1'b1;
            case (state)
                rx_idle: begin
                    cnt <= '0;
                    if (!rxd)               // falling start edge
                        state <= rx_start;
                end
                rx_start: begin
                    if (cnt == HALF) begin
                        cnt     <= '0;
                        bit_cnt <= '0;
                        state   <= rxd ? rx_idle : rx_data; // glitch, back to idle
                    end
                end
                rx_data: begin
                    if (cnt == LAST) begin  // middle of data bit
                        cnt     <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= rx_stop;
                    end
                end
                rx_stop: begin
                    if (cnt == LAST) begin  // middle of stop bit
                        cnt       <= '0;
                        rx_strobe <= rxd;   // framing error drops the byte
                        state     <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // lsb first into the top of the shifter
    always_ff @(posedge reg_clk) begin
        if (state == rx_data && cnt == LAST)
            shreg <= {rxd, shreg[7:1]};
    end

endmodule

`default_nettype wire

//--- design/note_stack.sv
`timescale 1ns/1ps
`default_nettype none

`include "synth_macros.svh"

module note_stack import synth_pkg::*; (
    input  wire                         reg_clk,
    input  wire                         reset_reg_N,
    input  wire  [`SYNTH_VOICES-1:0]    voice_free,   // engine has released voice
    input  wire                         ev_strobe,
    input  msg_kind_e                   ev_kind,
    input  wire  [6:0]                  ev_d1,
    input  wire  [6:0]                  ev_d2,
    output logic [`SYNTH_VOICES-1:0]    keys_on,
    output logic                        note_on,      // one cycle per triggered voice
    output logic [`SYNTH_V_WIDTH-1:0]   cur_key_adr,
    output logic [7:0]                  cur_key_val,
    output logic [7:0]                  cur_vel_on,
    output logic [7:0]                  cur_vel_off,
    output logic [`SYNTH_V_WIDTH:0]     active_keys
);

    logic [6:0]                key_reg [`SYNTH_VOICES];  // key held by each voice
    logic                      hit;                      // key already on a voice
    logic [`SYNTH_V_WIDTH-1:0] hit_idx;
    logic                      free;                     // a voice can be taken
    logic [`SYNTH_V_WIDTH-1:0] free_idx;
    logic                      ev_on;
    logic                      ev_off;
    logic                      ev_all_off;

    assign ev_on      = ev_strobe && (ev_kind == kind_note_on);
    assign ev_off     = ev_strobe && (ev_kind == kind_note_off);
    assign ev_all_off = ev_strobe && (ev_kind == kind_ctrl) && (ev_d1 == `MIDI_CTRL_ALL_OFF);

    // search from the top so the lowest match wins
    always_comb begin
        hit      = 1'b0;
        hit_idx  = '0;
        free     = 1'b0;
        free_idx = '0;
        for (int i = `SYNTH_VOICES - 1; i >= 0; i--) begin
            if (keys_on[i] && key_reg[i] == ev_d1) begin
                hit     = 1'b1;
                hit_idx = `SYNTH_V_WIDTH'(i);
            end
            if (!keys_on[i] && voice_free[i]) begin
                free     = 1'b1;
                free_idx = `SYNTH_V_WIDTH'(i);
            end
        end
    end

    always_comb begin
        active_keys = '0;
        for (int i = 0; i < `SYNTH_VOICES; i++)
            active_keys = active_keys + keys_on[i];
    end

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            keys_on <= '0;
            note_on <= 1'b0;
        end else begin
            note_on <= 1'b0;
            if (ev_on && hit) begin
                note_on <= 1'b1;            // retrigger same voice
            end else if (ev_on && free) begin
                keys_on[free_idx] <= 1'b1;
                note_on           <= 1'b1;
            end else if (ev_off && hit) begin
                keys_on[hit_idx] <= 1'b0;
            end else if (ev_all_off) begin
                keys_on <= '0;
            end
        end
    end

    // voice keys and note data
    always_ff @(posedge reg_clk) begin
        if (ev_on && (hit || free)) begin
            cur_key_adr <= hit ? hit_idx : free_idx;
            cur_key_val <= {1'b0, ev_d1};
            cur_vel_on  <= {1'b0, ev_d2};
        end
        if (ev_on && !hit && free)
            key_reg[free_idx] <= ev_d1;
        if (ev_off && hit)
            cur_vel_off <= {1'b0, ev_d2}; // release velocity
    end

endmodule

`default_nettype wire

//--- design/synth_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "synth_macros.svh"

module synth_controller import synth_pkg::*; (
    input  wire                         reset_reg_N,
    input  wire                         reg_clk,
    input  wire  [2:0]                  socmidi_addr,     // cpu register port
    input  wire  [7:0]                  socmidi_data_in,
    input  wire                         socmidi_write,
    input  wire                         midi_rxd,         // serial MIDI in
    input  wire                         uart_usb_sel,     // 1 uart, 0 cpu bytes
    input  wire  [`SYNTH_VOICES-1:0]    voice_free,       // from synth engine
    input  wire  [3:0]                  midi_ch,
    output logic [`SYNTH_VOICES-1:0]    keys_on,          // to synth engine
    output logic                        note_on,
    output logic [`SYNTH_V_WIDTH-1:0]   cur_key_adr,
    output logic [7:0]                  cur_key_val,
    output logic [7:0]                  cur_vel_on,
    output logic [7:0]                  cur_vel_off,
    output logic [`SYNTH_V_WIDTH:0]     active_keys,
    output logic                        ctrl_cmd,
    output logic                        prg_ch_cmd,
    output logic                        pitch_cmd,
    output logic [7:0]                  octrl,
    output logic [7:0]                  octrl_data,
    output logic [7:0]                  prg_ch_data
);

    logic       rx_strobe;                  // uart byte
    logic [7:0] rx_byte;
    logic       cpu_strobe;                 // cpu byte
    logic [7:0] cpu_byte;
    logic       omni;
    logic       ev_strobe;                  // parsed event bus
    msg_kind_e  ev_kind;
    logic [6:0] ev_d1;
    logic [6:0] ev_d2;

    midi_uart_rx i_uart_rx (
        .reg_clk     (reg_clk),
        .reset_reg_N (reset_reg_N),
        .midi_rxd    (midi_rxd),
        .rx_strobe   (rx_strobe),
        .rx_byte     (rx_byte)
    );

    cpu_port i_cpu_port (
        .reg_clk         (reg_clk),
        .reset_reg_N     (reset_reg_N),
        .socmidi_addr    (socmidi_addr),
        .socmidi_data_in (socmidi_data_in),
        .socmidi_write   (socmidi_write),
        .cpu_strobe      (cpu_strobe),
        .cpu_byte        (cpu_byte),
        .omni            (omni)
    );

    midi_parser i_parser (
        .reg_clk      (reg_clk),
        .reset_reg_N  (reset_reg_N),
        .uart_usb_sel (uart_usb_sel),
        .rx_strobe    (rx_strobe),
        .rx_byte      (rx_byte),
        .cpu_strobe   (cpu_strobe),
        .cpu_byte     (cpu_byte),
        .midi_ch      (midi_ch),
        .omni         (omni),
        .ev_strobe    (ev_strobe),
        .ev_kind      (ev_kind),
        .ev_d1        (ev_d1),
        .ev_d2        (ev_d2)
    );

    note_stack i_note_stack (
        .reg_clk     (reg_clk),
        .reset_reg_N (reset_reg_N),
        .voice_free  (voice_free),
        .ev_strobe   (ev_strobe),
        .ev_kind     (ev_kind),
        .ev_d1       (ev_d1),
        .ev_d2       (ev_d2),
        .keys_on     (keys_on),
        .note_on     (note_on),
        .cur_key_adr (cur_key_adr),
        .cur_key_val (cur_key_val),
        .cur_vel_on  (cur_vel_on),
        .cur_vel_off (cur_vel_off),
        .active_keys (active_keys)
    );

    ctrl_regs i_ctrl_regs (
        .reg_clk     (reg_clk),
        .reset_reg_N (reset_reg_N),
        .ev_strobe   (ev_strobe),
        .ev_kind     (ev_kind),
        .ev_d1       (ev_d1),
        .ev_d2       (ev_d2),
        .ctrl_cmd    (ctrl_cmd),
        .prg_ch_cmd  (prg_ch_cmd),
        .pitch_cmd   (pitch_cmd),
        .octrl       (octrl),
        .octrl_data  (octrl_data),
        .prg_ch_data (prg_ch_data)
    );

endmodule

`default_nettype wire

//--- design/synth_pkg.sv
`default_nettype none

package synth_pkg;

    // kind of a completed MIDI channel message
    typedef enum logic [2:0] {
        kind_none,                          // no valid running status
        kind_note_on,
        kind_note_off,                      // also note on with velocity 0
        kind_ctrl,                          // control change
        kind_prg,                           // program change, one data byte
        kind_pitch,                         // pitch bend, lsb then msb
        kind_other                          // aftertouch, consumed only
    } msg_kind_e;

    // serial receiver states
    typedef enum logic [1:0] {
        rx_idle,                            // line high, wait for start edge
        rx_start,                           // run to middle of start bit
        rx_data,                            // eight data bits, lsb first
        rx_stop                             // check stop bit
    } rx_state_e;

endpackage

`default_nettype wire

//--- include/synth_macros.svh
`ifndef SYNTH_MACROS_SVH
`define SYNTH_MACROS_SVH

// voice pool of the synth engine
`define SYNTH_VOICES 8
`define SYNTH_V_WIDTH 3

// reg_clk cycles per MIDI bit, short value for simulation
// hardware build needs clock / 31250 here
`define MIDI_CLKS_PER_BIT 16

// channel mode message, all notes off
`define MIDI_CTRL_ALL_OFF 7'd123

`endif

//--- test/synth_controller_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "synth_macros.svh"

module synth_controller_sva import synth_pkg::*; (
    input wire                        reg_clk,
    input wire                        reset_reg_N,
    input wire                        note_on,
    input wire                        ctrl_cmd,
    input wire                        prg_ch_cmd,
    input wire                        pitch_cmd,
    input wire [`SYNTH_VOICES-1:0]    keys_on,
    input wire [`SYNTH_V_WIDTH-1:0]   cur_key_adr,
    input wire [`SYNTH_V_WIDTH:0]     active_keys,
    input rx_state_e                  rx_state      // peeked from the uart
);

    int        fail_cnt = 0;                // read by the testbench
    wire [3:0] pulses;

    assign pulses = {note_on, ctrl_cmd, prg_ch_cmd, pitch_cmd};

    a_pulse_excl: assert property (@(posedge reg_clk) disable iff (!reset_reg_N)
        $onehot0(pulses))
        else begin fail_cnt++; $error("output pulses overlap"); end

    a_pulse_short: assert property (@(posedge reg_clk) disable iff (!reset_reg_N)
        pulses != 4'b0 |=> (pulses & $past(pulses)) == 4'b0)
        else begin fail_cnt++; $error("output pulse longer than one cycle"); end

    a_count: assert property (@(posedge reg_clk) disable iff (!reset_reg_N)
        active_keys == $countones(keys_on))
        else begin fail_cnt++; $error("active_keys differs from keys_on"); end

    a_note_key: assert property (@(posedge reg_clk) disable iff (!reset_reg_N)
        note_on |=> keys_on[cur_key_adr])
        else begin fail_cnt++; $error("triggered voice not held"); end

    a_reset_quiet: assert property (@(posedge reg_clk)
        !reset_reg_N |=> pulses == 4'b0 && keys_on == '0 && active_keys == '0
                         && rx_state == rx_idle)
        else begin fail_cnt++; $error("outputs active during reset"); end

endmodule

bind synth_controller synth_controller_sva i_sva (
    .reg_clk     (reg_clk),
    .reset_reg_N (reset_reg_N),
    .note_on     (note_on),
    .ctrl_cmd    (ctrl_cmd),
    .prg_ch_cmd  (prg_ch_cmd),
    .pitch_cmd   (pitch_cmd),
    .keys_on     (keys_on),
    .cur_key_adr (cur_key_adr),
    .active_keys (active_keys),
    .rx_state    (i_uart_rx.state)
);

`default_nettype wire

//--- test/tb_synth_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "synth_macros.svh"

module tb_synth_controller;

    localparam int CPB = `MIDI_CLKS_PER_BIT;
    localparam logic [1:0] P_NOTE = 2'd0;   // which output pulse an event expects
    localparam logic [1:0] P_CTRL = 2'd1;
    localparam logic [1:0] P_PRG = 2'd2;
    localparam logic [1:0] P_PITCH = 2'd3;

    typedef struct packed {
        logic       valid;
        logic [1:0] pulse;
        logic [7:0] v0;                     // voice or ctrl number or program
        logic [7:0] v1;                     // key or ctrl value
        logic [7:0] v2;                     // velocity
    } exp_t;

    logic                        reg_clk;
    logic                        reset_reg_N;
    logic [2:0]                  socmidi_addr;
    logic [7:0]                  socmidi_data_in;
    logic                        socmidi_write;
    logic                        midi_rxd;
    logic                        uart_usb_sel;
    logic [`SYNTH_VOICES-1:0]    voice_free;
    logic [3:0]                  midi_ch;
    logic [`SYNTH_VOICES-1:0]    keys_on;
    logic                        note_on;
    logic [`SYNTH_V_WIDTH-1:0]   cur_key_adr;
    logic [7:0]                  cur_key_val;
    logic [7:0]                  cur_vel_on;
    logic [7:0]                  cur_vel_off;
    logic [`SYNTH_V_WIDTH:0]     active_keys;
    logic                        ctrl_cmd;
    logic                        prg_ch_cmd;
    logic                        pitch_cmd;
    logic [7:0]                  octrl;
    logic [7:0]                  octrl_data;
    logic [7:0]                  prg_ch_data;

    exp_t                        exp_q[$];  // events still owed by the DUT
    int                          seed;
    logic [7:0]                  m_status;  // model running status
    int                          m_cnt;     // data bytes seen
    logic [6:0]                  m_first;
    logic                        m_omni;
    logic [`SYNTH_VOICES-1:0]    m_keys;
    logic [6:0]                  m_key [`SYNTH_VOICES];
    logic [7:0]                  m_vel_off;
    logic                        m_off_seen; // cur_vel_off written at least once

    synth_controller i_dut (
        .reset_reg_N     (reset_reg_N),
        .reg_clk         (reg_clk),
        .socmidi_addr    (socmidi_addr),
        .socmidi_data_in (socmidi_data_in),
        .socmidi_write   (socmidi_write),
        .midi_rxd        (midi_rxd),
        .uart_usb_sel    (uart_usb_sel),
        .voice_free      (voice_free),
        .midi_ch         (midi_ch),
        .keys_on         (keys_on),
        .note_on         (note_on),
        .cur_key_adr     (cur_key_adr),
        .cur_key_val     (cur_key_val),
        .cur_vel_on      (cur_vel_on),
        .cur_vel_off     (cur_vel_off),
        .active_keys     (active_keys),
        .ctrl_cmd        (ctrl_cmd),
        .prg_ch_cmd      (prg_ch_cmd),
        .pitch_cmd       (pitch_cmd),
        .octrl           (octrl),
        .octrl_data      (octrl_data),
        .prg_ch_data     (prg_ch_data)
    );

    initial begin
        reg_clk = 1'b0;
        forever #2 reg_clk = ~reg_clk;      // 4 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            abort_run($sformatf("error %0t: %s is %0h, expected %0h", $time, what, got, exp));
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge reg_clk);
        #1;                                 // drive just after the edge
    endtask

    function automatic exp_t pack_event(input logic [1:0] p, input logic [7:0] a,
                                        input logic [7:0] b, input logic [7:0] c);
        exp_t e;
        e.valid = 1'b1;
        e.pulse = p;
        e.v0 = a;
        e.v1 = b;
        e.v2 = c;
        return e;
    endfunction

    function automatic int held_voice(input logic [6:0] key);
        for (int i = 0; i < `SYNTH_VOICES; i++)
            if (m_keys[i] && m_key[i] == key)
                return i;
        return -1;
    endfunction

    function automatic int open_voice();
        for (int i = 0; i < `SYNTH_VOICES; i++)
            if (!m_keys[i] && voice_free[i])    // lowest idle voice wins
                return i;
        return -1;
    endfunction

    // allocation and controller rules on a completed message
    function automatic exp_t apply_event(input logic [3:0] hi, input logic [6:0] d1,
                                         input logic [6:0] d2);
        exp_t e;
        int v;
        e = '0;
        v = held_voice(d1);
        if (hi == 4'h9 && d2 != 7'd0) begin
            if (v < 0)
                v = open_voice();           // retrigger if held or take a new voice
            if (v >= 0) begin
                m_keys[v] = 1'b1;
                m_key[v] = d1;
                e = pack_event(P_NOTE, 8'(v), {1'b0, d1}, {1'b0, d2});
            end                             // overflow dropped
        end else if (hi == 4'h8 || hi == 4'h9) begin
            if (v >= 0) begin
                m_keys[v] = 1'b0;
                m_vel_off = {1'b0, d2};
                m_off_seen = 1'b1;
            end
        end else if (hi == 4'hb) begin
            if (d1 == `MIDI_CTRL_ALL_OFF)
                m_keys = '0;
            e = pack_event(P_CTRL, {1'b0, d1}, {1'b0, d2}, 8'h00);
        end else if (hi == 4'hc) begin
            e = pack_event(P_PRG, {1'b0, d1}, 8'h00, 8'h00);
        end else if (hi == 4'he) begin
            e = pack_event(P_PITCH, {1'b0, d1}, {1'b0, d2}, 8'h00);
        end                                 // aftertouch gives nothing
        return e;
    endfunction

    // parser rules on one accepted byte
    function automatic exp_t model_byte(input logic [7:0] b);
        exp_t e;
        logic [6:0] d1;
        logic [6:0] d2;
        e = '0;
        if (b[7] && b >= 8'hf0 && b < 8'hf8) begin
            m_status = 8'h00;               // sysex or common cancels status
            m_cnt = 0;
        end else if (b[7] && b < 8'hf0) begin
            m_status = b;
            m_cnt = 0;
        end else if (!b[7] && m_status[7]) begin
            if (m_cnt == 0 && m_status[7:4] != 4'hc && m_status[7:4] != 4'hd) begin
                m_first = b[6:0];
                m_cnt = 1;
            end else begin
                d1 = (m_cnt == 1) ? m_first : b[6:0];
                d2 = (m_cnt == 1) ? b[6:0] : 7'd0;
                m_cnt = 0;                  // ready for running status
                if (m_omni || m_status[3:0] == midi_ch)
                    e = apply_event(m_status[7:4], d1, d2);
            end
        end                                 // realtime bytes fall through
        return e;
    endfunction

    task automatic expect_byte(input logic [7:0] b);
        exp_t e;
        e = model_byte(b);
        if (e.valid)
            exp_q.push_back(e);
    endtask

    task automatic cpu_send(input logic [7:0] b);
        if (!uart_usb_sel)
            expect_byte(b);
        socmidi_addr = 3'd0;
        socmidi_data_in = b;
        socmidi_write = 1'b1;
        tick(1);
        socmidi_write = 1'b0;
    endtask

    task automatic uart_send(input logic [7:0] b);
        if (uart_usb_sel)
            expect_byte(b);
        midi_rxd = 1'b0;                    // start bit
        tick(CPB);
        for (int i = 0; i < 8; i++) begin
            midi_rxd = b[i];
            tick(CPB);
        end
        midi_rxd = 1'b1;                    // stop bit
        tick(CPB);
    endtask

    task automatic send_byte(input logic [7:0] b);
        if (uart_usb_sel) begin
            cpu_send(8'hf0);                // must be ignored by the parser
            uart_send(b);
        end else begin
            cpu_send(b);
        end
    endtask

    task automatic set_omni(input logic v);
        socmidi_addr = 3'd1;
        socmidi_data_in = {7'd0, v};
        socmidi_write = 1'b1;
        m_omni = v;
        tick(1);
        socmidi_write = 1'b0;
        socmidi_addr = 3'd0;
    endtask

    // drain owed pulses then let the 3 cycle path finish
    task automatic settle();
        int t;
        t = 0;
        while (exp_q.size() != 0) begin
            tick(1);
            t++;
            if (t > 400)
                abort_run("timeout: an expected output pulse never came");
        end
        tick(3);
        check_eq(keys_on, m_keys, "keys_on");
        check_eq(active_keys, $countones(m_keys), "active_keys");
        if (m_off_seen)
            check_eq(cur_vel_off, m_vel_off, "cur_vel_off");
    endtask

    task automatic msg2(input logic [7:0] a, input logic [7:0] b);
        send_byte(a);
        send_byte(b);
        settle();
    endtask

    task automatic msg3(input logic [7:0] a, input logic [7:0] b, input logic [7:0] c);
        send_byte(a);
        send_byte(b);
        send_byte(c);
        settle();
    endtask

    task automatic apply_reset();
        reset_reg_N = 1'b0;
        m_status = 8'h00;
        m_cnt = 0;
        m_omni = 1'b0;
        m_keys = '0;
        m_off_seen = 1'b0;
        seed = 32'hdb3fa2dc;                // same random run on both sources
        tick(16);
        reset_reg_N = 1'b1;
        tick(1);
    endtask

    task automatic run_sequence();
        int r;
        logic [3:0] ch;
        voice_free = '1;
        msg3(8'h95, 8'h3c, 8'h64);          // note on for channel 5
        msg3(8'h85, 8'h3c, 8'h20);
        msg3(8'h95, 8'h40, 8'h50);
        msg2(8'h40, 8'h00);                 // velocity 0 release
        msg2(8'h30, 8'h10);                 // running status
        send_byte(8'hf8);
        msg2(8'h32, 8'h11);
        send_byte(8'h34);
        send_byte(8'hf8);                   // clock inside a message
        send_byte(8'h12);
        settle();
        send_byte(8'hf0);
        msg2(8'h36, 8'h13);                 // dropped without status
        msg3(8'hb5, 8'h7b, 8'h00);          // all notes off
        msg3(8'h93, 8'h40, 8'h40);          // other channel
        set_omni(1'b1);
        msg3(8'h93, 8'h41, 8'h40);
        set_omni(1'b0);
        msg3(8'hb3, 8'h7b, 8'h00);
        msg3(8'hb5, 8'h7b, 8'h00);
        voice_free = 8'b1111_1011;          // engine still busy on voice 2
        send_byte(8'h95);
        for (int i = 0; i < 9; i++)
            msg2(8'(8'h50 + i), 8'(8'h30 + i)); // last two overflow
        msg2(8'h52, 8'h7f);                 // retrigger
        msg2(8'h50, 8'h00);
        msg2(8'h60, 8'h22);
        msg3(8'hb5, 8'h7b, 8'h00);
        voice_free = '1;
        msg2(8'hc5, 8'h12);
        msg3(8'he5, 8'h01, 8'h40);
        msg3(8'hb5, 8'h07, 8'h64);
        msg2(8'h0a, 8'h20);
        msg3(8'ha5, 8'h3c, 8'h10);          // poly aftertouch
        msg2(8'hd5, 8'h20);                 // channel pressure
        msg3(8'h95, 8'h3d, 8'h11);
        for (int i = 0; i < 24; i++) begin
            r = $random(seed);
            ch = r[12] ? midi_ch : r[11:8];
            msg3({3'b100, r[24], ch}, {1'b0, r[6:0]}, {1'b0, r[22:16]});
        end
        msg3(8'hb5, 8'h7b, 8'h00);
    endtask

    // compare every output pulse with the oldest owed event
    initial begin
        exp_t e;
        logic [1:0] code;
        forever begin
            @(negedge reg_clk);
            if (i_dut.i_sva.fail_cnt != 0)
                abort_run("a bound assertion on the DUT outputs failed");
            if (note_on || ctrl_cmd || prg_ch_cmd || pitch_cmd) begin
                if (exp_q.size() == 0) begin
                    abort_run($sformatf("error %0t: output pulse with no event due", $time));
                end else begin
                    e = exp_q.pop_front();
                    code = note_on ? P_NOTE : ctrl_cmd ? P_CTRL : prg_ch_cmd ? P_PRG : P_PITCH;
                    check_eq(code, e.pulse, "pulse kind");
                    case (e.pulse)
                        P_NOTE: begin
                            check_eq(cur_key_adr, e.v0, "cur_key_adr");
                            check_eq(cur_key_val, e.v1, "cur_key_val");
                            check_eq(cur_vel_on, e.v2, "cur_vel_on");
                        end
                        P_PRG: check_eq(prg_ch_data, e.v0, "prg_ch_data");
                        default: begin
                            check_eq(octrl, e.v0, "octrl");
                            check_eq(octrl_data, e.v1, "octrl_data");
                        end
                    endcase
                end
            end
        end
    end

    initial begin
        reset_reg_N = 1'b0;
        socmidi_addr = 3'd0;
        socmidi_data_in = 8'h00;
        socmidi_write = 1'b0;
        midi_rxd = 1'b1;                    // line idle
        uart_usb_sel = 1'b0;
        voice_free = '1;
        midi_ch = 4'd5;
        apply_reset();
        run_sequence();                     // cpu bytes
        uart_usb_sel = 1'b1;
        apply_reset();
        run_sequence();                     // serial bytes
        if (i_dut.i_sva.fail_cnt == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            abort_run("a bound assertion on the DUT outputs failed");
        end
    end

endmodule

`default_nettype wire
